// File: src/memStagePkg.sv
// memory stage shared definitions
// access kinds, exception codes, the execute-to-memory bundle and
// the word view used for byte and halfword lane handling

`default_nettype none

package memStagePkg;

    // ==================================================================
    // access kinds
    // ==================================================================
    typedef enum logic [2:0] {
        loadNone  = 3'd0,
        loadByteS = 3'd1,
        loadByteU = 3'd2,
        loadHalfS = 3'd3,
        loadHalfU = 3'd4,
        loadWord  = 3'd5
    } loadKind;

    typedef enum logic [1:0] {
        storeNone = 2'd0,
        storeByte = 2'd1,
        storeHalf = 2'd2,
        storeWord = 2'd3
    } storeKind;

    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbHi   = 2'd2,
        wbLo   = 2'd3
    } wbSource;

    // ==================================================================
    // exceptions
    // ==================================================================
    // zero means no exception, so an all-zero bundle is a clean bubble
    typedef enum logic [4:0] {
        excNone = 5'h00,
        excInt  = 5'h01,
        excAdEL = 5'h04,
        excAdES = 5'h05,
        excSys  = 5'h08,
        excBp   = 5'h09,
        excRi   = 5'h0a,
        excOv   = 5'h0c,
        excTrap = 5'h0d
    } exceptCode;

    typedef struct packed {
        exceptCode   code;
        logic [31:0] badVAddr;
    } exceptInfo;

    // one data word seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } memWord;

    // ==================================================================
    // pipeline bundles
    // ==================================================================
    typedef struct packed {
        logic [31:0] aluOut;
        logic [31:0] storeData;
        logic [31:0] pc;
        logic [4:0]  dst;
        logic        regWrite;
        loadKind     ldKind;
        storeKind    stKind;
        wbSource     wbSrc;
        logic [31:0] hi;
        logic [31:0] lo;
        exceptInfo   exc;
    } exeMemBundle;

    typedef struct packed {
        logic [31:0] loadData;
        logic [3:0]  byteEnable;
        logic        memWrite;
    } lsuResult;

endpackage

`default_nettype wire

// File: src/exeMemReg.sv
// execute to memory pipeline register
// captures the execute bundle on the write strobe and loads a bubble on flush

`timescale 1ns/100ps
`default_nettype none

module exeMemReg
    import memStagePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        memWr,
    input  exeMemBundle exeIn,
    output exeMemBundle memIn
);

    // flush wins over the write strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            memIn <= '0;
        end else if (flush) begin
            memIn <= '0;
        end else if (memWr) begin
            memIn <= exeIn;
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // a flushed slot must look like a bubble downstream
    flushGivesBubble: assert property (
        @(posedge clk) disable iff (!rst)
        flush |=> (memIn == '0)
    ) else $error("exeMemReg: bundle not cleared after flush");

    // register zero is never a writeback target
    noWriteToZero: assert property (
        @(posedge clk) disable iff (!rst)
        !(memIn.regWrite && (memIn.dst == 5'd0))
    ) else $error("exeMemReg: regWrite set with dst zero");

endmodule

`default_nettype wire

// File: src/loadStoreUnit.sv
// load/store unit
// builds byte enables and lane-replicated store data for the data memory,
// then picks the addressed byte or half out of the read word and extends it

`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit
    import memStagePkg::*;
(
    input  exeMemBundle memIn,
    input  logic [31:0] dataRdata,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output lsuResult    lsu
);

    logic [1:0] offset;
    memWord     wrWord;
    memWord     rdWord;
    logic [3:0] byteEn;
    logic [7:0] selByte;
    logic [15:0] selHalf;

    assign offset   = memIn.aluOut[1:0];
    assign dataAddr = {memIn.aluOut[31:2], 2'b00};

    // ==================================================================
    // store side
    // ==================================================================
    always_comb begin
        wrWord = memIn.storeData;
        byteEn = 4'b0000;
        case (memIn.stKind)
            storeByte: begin
                wrWord.bytes = {4{memIn.storeData[7:0]}};
                byteEn       = 4'b0001 << offset;
            end
            storeHalf: begin
                wrWord.halves = {2{memIn.storeData[15:0]}};
                // address bit 1 picks the upper half
                byteEn        = offset[1] ? 4'b1100 : 4'b0011;
            end
            storeWord: begin
                byteEn = 4'b1111;
            end
            default: begin
                byteEn = 4'b0000;
            end
        endcase
    end

    assign dataWdata = wrWord;

    // ==================================================================
    // load side
    // ==================================================================
    assign rdWord  = dataRdata;
    assign selByte = rdWord.bytes[offset];
    assign selHalf = rdWord.halves[offset[1]];

    always_comb begin
        case (memIn.ldKind)
            loadByteS: lsu.loadData = {{24{selByte[7]}}, selByte};
            loadByteU: lsu.loadData = {24'd0, selByte};
            loadHalfS: lsu.loadData = {{16{selHalf[15]}}, selHalf};
            loadHalfU: lsu.loadData = {16'd0, selHalf};
            loadWord:  lsu.loadData = rdWord;
            default:   lsu.loadData = 32'd0;
        endcase
        lsu.byteEnable = byteEn;
        // exception gating happens in the writeback combiner
        lsu.memWrite   = (memIn.stKind != storeNone);
    end

    // byte store drives one lane, and that lane carries the store byte
    always_comb begin
        if (memIn.stKind == storeByte) begin
            byteStoreOneLane: assert final (
                $onehot(lsu.byteEnable) &&
                (wrWord.bytes[offset] == memIn.storeData[7:0])
            ) else $error("loadStoreUnit: bad byte store lane");
        end
    end

endmodule

`default_nettype wire

// File: src/memExceptCheck.sv
// memory stage exception check
// flags misaligned half and word accesses, earlier exceptions take priority

`timescale 1ns/100ps
`default_nettype none

module memExceptCheck
    import memStagePkg::*;
(
    input  exeMemBundle memIn,
    output exceptInfo   except
);

    logic halfAccess;
    logic wordAccess;
    logic misaligned;
    logic isStore;

    assign halfAccess = (memIn.ldKind == loadHalfS) || (memIn.ldKind == loadHalfU) ||
                        (memIn.stKind == storeHalf);
    assign wordAccess = (memIn.ldKind == loadWord) || (memIn.stKind == storeWord);
    assign misaligned = (halfAccess && memIn.aluOut[0]) ||
                        (wordAccess && (memIn.aluOut[1:0] != 2'b00));
    assign isStore    = (memIn.stKind != storeNone);

    always_comb begin
        if (memIn.exc.code != excNone) begin
            // passed through untouched
            except = memIn.exc;
        end else if (misaligned) begin
            except.code     = isStore ? excAdES : excAdEL;
            except.badVAddr = memIn.aluOut;
        end else begin
            except.code     = excNone;
            except.badVAddr = 32'd0;
        end
    end

    // decode upstream never issues a load and a store together
    always_comb begin
        oneAccessKind: assert final (
            (memIn.ldKind == loadNone) || (memIn.stKind == storeNone)
        ) else $error("memExceptCheck: load and store both active");
    end

endmodule

`default_nettype wire

// File: src/memWriteback.sv
// memory stage writeback combiner
// picks the register writeback word and blocks register and memory
// writes whenever an exception is pending

`timescale 1ns/100ps
`default_nettype none

module memWriteback
    import memStagePkg::*;
(
    input  exeMemBundle memIn,
    input  lsuResult    lsu,
    input  exceptInfo   except,
    output logic        dataWe,
    output logic [3:0]  dataBe,
    output logic        regWe,
    output logic [4:0]  regDst,
    output logic [31:0] regWdata
);

    logic excActive;

    assign excActive = (except.code != excNone);

    // ==================================================================
    // writeback select
    // ==================================================================
    always_comb begin
        case (memIn.wbSrc)
            wbAlu:   regWdata = memIn.aluOut;
            wbLoad:  regWdata = lsu.loadData;
            wbHi:    regWdata = memIn.hi;
            wbLo:    regWdata = memIn.lo;
            default: regWdata = memIn.aluOut;
        endcase
    end

    // ==================================================================
    // write gating
    // ==================================================================
    // faulting instruction must leave no trace in memory or registers
    assign dataWe = lsu.memWrite && !excActive;
    assign dataBe = excActive ? 4'b0000 : lsu.byteEnable;
    assign regWe  = memIn.regWrite && !excActive;
    assign regDst = memIn.dst;

endmodule

`default_nettype wire

// File: src/memStage.sv
// memory stage top
// pipeline register feeding the load/store unit and the exception check
// side by side, both merged by the writeback combiner

`timescale 1ns/100ps
`default_nettype none

module memStage
    import memStagePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        memWr,
    input  exeMemBundle exeIn,
    input  logic [31:0] dataRdata,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWe,
    output logic [3:0]  dataBe,
    output logic        regWe,
    output logic [4:0]  regDst,
    output logic [31:0] regWdata,
    output exceptInfo   except
);

    exeMemBundle memIn;
    lsuResult    lsu;

    exeMemReg i_exeMemReg (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .memWr (memWr),
        .exeIn (exeIn),
        .memIn (memIn)
    );

    // the two parallel halves of the stage
    loadStoreUnit i_loadStoreUnit (
        .memIn     (memIn),
        .dataRdata (dataRdata),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .lsu       (lsu)
    );

    memExceptCheck i_memExceptCheck (
        .memIn  (memIn),
        .except (except)
    );

    memWriteback i_memWriteback (
        .memIn    (memIn),
        .lsu      (lsu),
        .except   (except),
        .dataWe   (dataWe),
        .dataBe   (dataBe),
        .regWe    (regWe),
        .regDst   (regDst),
        .regWdata (regWdata)
    );

endmodule

`default_nettype wire

// File: tb/memStageTb.sv
// memory stage testbench
// drives execute bundles into the stage, models the data memory and
// compares every cycle against a reference model of the stage rules

`timescale 1ns/100ps
`default_nettype none

module memStageTb
    import memStagePkg::*;
();

    localparam int clkPeriod   = 8;
    localparam int memWords    = 256;
    localparam int opCount     = 480;
    localparam int cycleBudget = opCount * 2 + 100;

    typedef struct packed {
        logic [31:0] dataAddr;
        logic [31:0] dataWdata;
        logic        dataWe;
        logic [3:0]  dataBe;
        logic        regWe;
        logic [4:0]  regDst;
        logic [31:0] regWdata;
        exceptInfo   except;
    } stageOut;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        memWr;
    exeMemBundle exeIn;
    logic [31:0] dataRdata;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataWe;
    logic [3:0]  dataBe;
    logic        regWe;
    logic [4:0]  regDst;
    logic [31:0] regWdata;
    exceptInfo   except;

    logic [31:0] mem [memWords];
    logic [31:0] refMem [memWords];
    exeMemBundle expBundle;
    logic [31:0] lcgState;

    memStage i_memStage (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .memWr     (memWr),
        .exeIn     (exeIn),
        .dataRdata (dataRdata),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .dataBe    (dataBe),
        .regWe     (regWe),
        .regDst    (regDst),
        .regWdata  (regWdata),
        .except    (except)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // ==================================================================
    // data memory model
    // ==================================================================
    assign dataRdata = mem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            for (int i = 0; i < 4; i++) begin
                if (dataBe[i]) begin
                    mem[dataAddr[9:2]][8*i +: 8] <= dataWdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] fillWord(int i);
        return {i[7:0] ^ 8'ha5, ~i[7:0], i[7:0] + 8'h3c, i[7:0]};
    endfunction

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        // upper bits first since the low LCG bits cycle too fast
        return {lcgState[15:0], lcgState[31:16]};
    endfunction

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic stageOut refModel(exeMemBundle b);
        stageOut     r;
        logic [1:0]  off;
        logic [31:0] word;
        logic [7:0]  bt;
        logic [15:0] hf;
        logic [31:0] loadVal;
        logic [3:0]  be;
        logic        halfAcc;
        logic        wordAcc;
        logic        hasExc;

        off  = b.aluOut[1:0];
        word = refMem[b.aluOut[9:2]];
        bt   = word[8*off +: 8];
        hf   = word[16*off[1] +: 16];
        case (b.ldKind)
            loadByteS: loadVal = {{24{bt[7]}}, bt};
            loadByteU: loadVal = {24'd0, bt};
            loadHalfS: loadVal = {{16{hf[15]}}, hf};
            loadHalfU: loadVal = {16'd0, hf};
            loadWord:  loadVal = word;
            default:   loadVal = 32'd0;
        endcase
        case (b.stKind)
            storeByte: be = 4'b0001 << off;
            storeHalf: be = off[1] ? 4'b1100 : 4'b0011;
            storeWord: be = 4'b1111;
            default:   be = 4'b0000;
        endcase
        r.dataWdata = b.storeData;
        if (b.stKind == storeByte) begin
            r.dataWdata = {4{b.storeData[7:0]}};
        end else if (b.stKind == storeHalf) begin
            r.dataWdata = {2{b.storeData[15:0]}};
        end

        halfAcc = (b.ldKind inside {loadHalfS, loadHalfU}) || (b.stKind == storeHalf);
        wordAcc = (b.ldKind == loadWord) || (b.stKind == storeWord);
        if (b.exc.code != excNone) begin
            r.except = b.exc;
        end else if ((halfAcc && off[0]) || (wordAcc && (off != 2'b00))) begin
            r.except.code     = (b.stKind != storeNone) ? excAdES : excAdEL;
            r.except.badVAddr = b.aluOut;
        end else begin
            r.except.code     = excNone;
            r.except.badVAddr = 32'd0;
        end
        hasExc = (r.except.code != excNone);

        r.dataAddr = {b.aluOut[31:2], 2'b00};
        r.dataWe   = (b.stKind != storeNone) && !hasExc;
        r.dataBe   = hasExc ? 4'b0000 : be;
        r.regWe    = b.regWrite && !hasExc;
        r.regDst   = b.dst;
        case (b.wbSrc)
            wbLoad:  r.regWdata = loadVal;
            wbHi:    r.regWdata = b.hi;
            wbLo:    r.regWdata = b.lo;
            default: r.regWdata = b.aluOut;
        endcase
        return r;
    endfunction

    task automatic applyStore(stageOut e);
        for (int i = 0; i < 4; i++) begin
            if (e.dataBe[i]) begin
                refMem[e.dataAddr[9:2]][8*i +: 8] = e.dataWdata[8*i +: 8];
            end
        end
    endtask

    // expected register content and the shadow memory stores
    always @(posedge clk or negedge rst) begin : trackStage
        stageOut lastOut;
        if (!rst) begin
            expBundle <= '0;
        end else begin
            lastOut = refModel(expBundle);
            if (lastOut.dataWe) begin
                applyStore(lastOut);
            end
            if (flush) begin
                expBundle <= '0;
            end else if (memWr) begin
                expBundle <= exeIn;
            end
        end
    end

    // ==================================================================
    // checks
    // ==================================================================
    task automatic reportFailure(string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "memory stage testbench stopped");
    endtask

    function automatic stageOut sampleOutputs();
        return {dataAddr, dataWdata, dataWe, dataBe, regWe, regDst, regWdata, except};
    endfunction

    task automatic checkOutputs();
        stageOut expOut;
        stageOut actOut;
        expOut = refModel(expBundle);
        actOut = sampleOutputs();
        // write data only means something on a store
        if (expBundle.stKind == storeNone) begin
            actOut.dataWdata = expOut.dataWdata;
        end
        outputsMatch: assert (actOut == expOut) else
            reportFailure($sformatf(
                "mismatch at %0t: pc %h regWe %b/%b regWdata %h/%h dataWe %b/%b be %b/%b exc %h/%h",
                $time, expBundle.pc, actOut.regWe, expOut.regWe, actOut.regWdata,
                expOut.regWdata, actOut.dataWe, expOut.dataWe, actOut.dataBe, expOut.dataBe,
                actOut.except, expOut.except));
    endtask

    always @(negedge clk) begin
        if (rst) begin
            checkOutputs();
        end
    end

    task automatic checkQuiet(string when);
        stageQuiet: assert (!regWe && !dataWe && (dataBe == 4'd0) && (except.code == excNone))
        else
            reportFailure($sformatf("mismatch at %0t: stage not idle %s", $time, when));
    endtask

    task automatic compareMemory();
        for (int i = 0; i < memWords; i++) begin
            memMatches: assert (mem[i] == refMem[i]) else
                reportFailure($sformatf("mismatch at %0t: memory word %0d is %h, expected %h",
                    $time, i, mem[i], refMem[i]));
        end
    endtask

    // ==================================================================
    // stimulus
    // ==================================================================
    function automatic exeMemBundle makeOp(logic [31:0] addr, loadKind lk, storeKind sk,
                                           wbSource ws, logic [4:0] dst);
        exeMemBundle b;
        b           = '0;
        b.aluOut    = addr;
        b.storeData = lcgNext();
        b.pc        = lcgNext();
        b.hi        = lcgNext();
        b.lo        = lcgNext();
        b.ldKind    = lk;
        b.stKind    = sk;
        b.wbSrc     = ws;
        b.dst       = dst;
        b.regWrite  = (sk == storeNone) && (dst != 5'd0);
        return b;
    endfunction

    function automatic exeMemBundle randomOp();
        exeMemBundle b;
        logic [31:0] r;
        logic [4:0]  dst;
        r   = lcgNext();
        dst = 5'(1 + r[12:8] % 31);
        case (r[1:0])
            2'd0:    b = makeOp(lcgNext(), loadNone, storeNone, wbAlu, r[12:8]);
            2'd1:    b = makeOp(lcgNext(), loadKind'(3'(1 + r[6:4] % 5)), storeNone,
                                wbLoad, dst);
            2'd2:    b = makeOp(lcgNext(), loadNone, storeKind'(2'(1 + r[5:4] % 3)),
                                wbAlu, dst);
            default: b = makeOp(lcgNext(), loadNone, storeNone, r[4] ? wbHi : wbLo, dst);
        endcase
        if (r[20:17] == 4'd0) begin
            b.exc.code     = excOv;
            b.exc.badVAddr = b.pc;
        end
        return b;
    endfunction

    task automatic issue(exeMemBundle b);
        @(posedge clk);
        exeIn <= b;
        memWr <= 1'b1;
        flush <= 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            memWr <= 1'b0;
            flush <= 1'b0;
        end
    endtask

    task automatic issueAtOffset(loadKind lk, storeKind sk, int off);
        logic [31:0] r;
        r = lcgNext();
        issue(makeOp({r[31:2], 2'(off)}, lk, sk, (lk == loadNone) ? wbAlu : wbLoad,
                     5'(1 + r[12:8] % 31)));
    endtask

    initial begin : mainSeq
        exceptCode   codes [4];
        stageOut     held;
        exeMemBundle b;
        logic [31:0] r;

        codes    = '{excOv, excSys, excRi, excInt};
        lcgState = 32'h7063;
        rst      = 1'b0;
        flush    = 1'b0;
        memWr    = 1'b0;
        exeIn    = '0;
        for (int i = 0; i < memWords; i++) begin
            mem[i]    = fillWord(i);
            refMem[i] = fillWord(i);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkQuiet("after reset");

        // aligned stores, then aligned loads of every kind
        for (int k = 1; k < 4; k++) begin
            for (int off = 0; off < 4; off++) begin
                if ((k == 1) || (k == 2 && off % 2 == 0) || (k == 3 && off == 0)) begin
                    issueAtOffset(loadNone, storeKind'(2'(k)), off);
                end
            end
        end
        idle(2);
        @(negedge clk);
        compareMemory();
        for (int k = 1; k < 6; k++) begin
            for (int off = 0; off < 4; off++) begin
                if (k < 3 || (k < 5 && off % 2 == 0) || off == 0) begin
                    issueAtOffset(loadKind'(3'(k)), storeNone, off);
                end
            end
        end

        // misaligned half and word accesses
        for (int off = 1; off < 4; off++) begin
            if (off != 2) begin
                issueAtOffset(loadHalfS, storeNone, off);
                issueAtOffset(loadNone, storeHalf, off);
            end
            issueAtOffset(loadWord, storeNone, off);
            issueAtOffset(loadNone, storeWord, off);
        end
        idle(2);
        @(negedge clk);
        compareMemory();

        // earlier-stage exceptions, then plain writeback selects
        for (int i = 0; i < 4; i++) begin
            r              = lcgNext();
            b              = makeOp({r[31:2], 2'b00}, loadNone, (i % 2 == 0) ? storeWord :
                                    storeNone, wbAlu, 5'd7);
            b.exc.code     = codes[i];
            b.exc.badVAddr = lcgNext();
            issue(b);
        end
        issue(makeOp(lcgNext(), loadNone, storeNone, wbAlu, 5'd3));
        issue(makeOp(lcgNext(), loadNone, storeNone, wbHi, 5'd4));
        issue(makeOp(lcgNext(), loadNone, storeNone, wbLo, 5'd5));

        // held register while the inputs keep moving
        issueAtOffset(loadNone, storeByte, 2);
        idle(1);
        @(negedge clk);
        held = sampleOutputs();
        repeat (5) begin
            @(posedge clk);
            exeIn <= randomOp();
            @(negedge clk);
            holdStable: assert (sampleOutputs() == held) else
                reportFailure($sformatf("mismatch at %0t: outputs moved while held", $time));
        end

        // flush beats the write strobe
        @(posedge clk);
        exeIn <= randomOp();
        memWr <= 1'b1;
        flush <= 1'b1;
        idle(1);
        @(negedge clk);
        checkQuiet("after flush");

        for (int n = 0; n < 400; n++) begin
            r = lcgNext();
            @(posedge clk);
            exeIn <= randomOp();
            memWr <= (r[2:0] != 3'd0);
            flush <= (r[7:3] == 5'd0);
        end
        idle(2);
        @(negedge clk);
        compareMemory();

        $display("All tests passed!");
        $finish;
    end

    initial begin : watchdog
        #(cycleBudget * clkPeriod);
        reportFailure("timeout: the memory stage tests did not finish in time");
    end

endmodule

`default_nettype wire

// File: all.f
src/memStagePkg.sv
src/exeMemReg.sv
src/loadStoreUnit.sv
src/memExceptCheck.sv
src/memWriteback.sv
src/memStage.sv
tb/memStageTb.sv

// File: Makefile
# Verilator build and run for the memory stage testbench

SOURCES := $(shell cat all.f)

obj_dir/VmemStageTb: all.f $(SOURCES)
	verilator --binary --timing --assert -f all.f --top-module memStageTb \
		-Mdir obj_dir -o VmemStageTb

run: obj_dir/VmemStageTb
	@out="$$(./obj_dir/VmemStageTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF 'All tests passed!'

clean:
	rm -rf obj_dir

.PHONY: run clean
